// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tage_tb \
    -f tage.f -o tage_sim > build.log 2>&1 &&
./obj_dir/tage_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed"; exit 1; }
grep -q "CHECKS FAILED" sim.log &&
{ echo "simulation failed, see sim.log"; exit 1; } ||
echo "simulation passed"

// ==== tage.f ====
tage_pkg.sv
tage_lfsr.sv
tage_hash.sv
tage_bank.sv
tage_predictor.sv
tage_top.sv
tage_chk.sv
tage_tb.sv

// ==== tage_bank.sv ====
`timescale 1ns/1ps

module tage_bank
    import tage_pkg::*;
#(
    parameter int index_bits = 6,
    parameter int tag_bits   = 8,
    parameter int hist_len   = hist_len_0
)(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lookup_valid,
    input  logic [index_bits-1:0]  index,
    input  logic [tag_bits-1:0]    tag,
    output logic [ctr_bits-1:0]    ctr_out,
    output logic [useful_bits-1:0] useful_out,
    output logic                   hit_out,
    input  logic                   update_en,
    input  logic [index_bits-1:0]  update_index,
    input  logic [tag_bits-1:0]    update_tag,
    input  logic [ctr_bits-1:0]    update_ctr,
    input  logic                   set_entry,
    input  logic                   inc_useful,
    input  logic                   dec_useful,
    input  logic                   refresh_hi,
    input  logic                   refresh_lo
);

    localparam int entries = 1 << index_bits;

    logic                   valid_mem  [entries];
    logic [tag_bits-1:0]    tag_mem    [entries];
    logic [ctr_bits-1:0]    ctr_mem    [entries];
    logic [useful_bits-1:0] useful_mem [entries];

    logic [index_bits-1:0]  last_index;  // entry of the last read
    logic [index_bits-1:0]  u_index;
    logic [useful_bits-1:0] u_cur;

    // a decay without a counter write targets the entry read last
    assign u_index = update_en ? update_index : last_index;
    assign u_cur   = useful_mem[u_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                valid_mem[i]  <= 1'b0;
                tag_mem[i]    <= '0;
                ctr_mem[i]    <= '0;
                useful_mem[i] <= '0;
            end
            ctr_out    <= '0;
            useful_out <= '0;
            hit_out    <= 1'b0;
            last_index <= '0;
        end else begin
            //////////////////////////////////////////////////
            // lookup
            //////////////////////////////////////////////////
            if (lookup_valid) begin
                ctr_out    <= ctr_mem[index];
                useful_out <= useful_mem[index];
                hit_out    <= valid_mem[index] && (tag_mem[index] == tag);
                last_index <= index;
            end

            //////////////////////////////////////////////////
            // update
            //////////////////////////////////////////////////
            if (update_en) begin
                ctr_mem[update_index] <= update_ctr;
                if (set_entry) begin  // new allocation
                    tag_mem[update_index]   <= update_tag;
                    valid_mem[update_index] <= 1'b1;
                end
            end

            if (update_en && set_entry) begin
                useful_mem[update_index] <= '0;
            end else if (inc_useful && u_cur != '1) begin
                useful_mem[u_index] <= u_cur + 1'b1;  // saturates at max
            end else if (dec_useful && u_cur != '0) begin
                useful_mem[u_index] <= u_cur - 1'b1;
            end

            // refresh wins over a same cycle useful write
            for (int i = 0; i < entries; i++) begin
                if (refresh_hi) begin
                    useful_mem[i][useful_bits-1] <= 1'b0;
                end
                if (refresh_lo) begin
                    useful_mem[i][0] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== tage_chk.sv ====
`timescale 1ns/1ps

module tage_chk (
    input logic       clk,
    input logic       reset,
    input logic       pred_req,
    input logic       pred_ack,
    input logic       pred_taken,
    input logic       pred_hit,
    input logic [1:0] pred_provider,
    input logic       commit_req,
    input logic       commit_ack
);

    //////////////////////////////////////////////////
    // four-phase handshake rules
    //////////////////////////////////////////////////

    // req as seen on the edge that changed the ack
    pred_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(pred_ack) |-> $past(pred_req)) else $error("pred_ack rose without pred_req");
    commit_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(commit_ack) |-> $past(commit_req))
        else $error("commit_ack rose without commit_req");
    pred_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(pred_ack) |-> $past(!pred_req)) else $error("pred_ack fell with pred_req high");
    commit_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(commit_ack) |-> $past(!commit_req))
        else $error("commit_ack fell with commit_req high");

    // result held for the whole ack phase
    pred_stable: assert property (@(posedge clk) disable iff (reset)
        pred_ack && $past(pred_ack) |-> $stable({pred_taken, pred_hit, pred_provider}))
        else $error("prediction changed while pred_ack high");
    acks_apart: assert property (@(posedge clk) disable iff (reset)
        !(pred_ack && commit_ack)) else $error("both acks high");

endmodule

bind tage_top tage_chk chk (
    .clk(clk), .reset(reset), .pred_req(pred_req), .pred_ack(pred_ack),
    .pred_taken(pred_taken), .pred_hit(pred_hit), .pred_provider(pred_provider),
    .commit_req(commit_req), .commit_ack(commit_ack)
);

// ==== tage_hash.sv ====
`timescale 1ns/1ps

module tage_hash
    import tage_pkg::*;
#(
    parameter int index_bits = 6,
    parameter int tag_bits   = 8
)(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  lookup,
    input  logic [31:0]                           pc,
    input  logic                                  hist_push,
    input  logic                                  hist_taken,
    output logic [num_banks-1:0][index_bits-1:0]  bank_index,
    output logic [num_banks-1:0][tag_bits-1:0]    bank_tag
);

    logic [max_hist-1:0]                  hist;  // bit 0 is the newest outcome
    logic [num_banks-1:0][index_bits-1:0] next_index;
    logic [num_banks-1:0][tag_bits-1:0]   next_tag;

    // xor the first len bits of history down to width bits
    function automatic logic [31:0] fold(input logic [max_hist-1:0] h, input int len,
                                         input int width);
        logic [31:0] f;
        f = '0;
        for (int i = 0; i < max_hist; i++) begin
            if (i < len) begin
                f[i % width] = f[i % width] ^ h[i];
            end
        end
        return f;
    endfunction

    always_comb begin : hash_calc
        logic [31:0] fi;
        logic [31:0] ft;
        for (int b = 0; b < num_banks; b++) begin
            fi = fold(hist, hist_lens[b], index_bits);
            ft = fold(hist, hist_lens[b], tag_bits);
            next_index[b] = pc[2 +: index_bits] ^ fi[index_bits-1:0];
            // tag folding rotated left by one so it differs from the index fold
            next_tag[b] = pc[2+index_bits +: tag_bits]
                        ^ {ft[tag_bits-2:0], ft[tag_bits-1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hist       <= '0;
            bank_index <= '0;
            bank_tag   <= '0;
        end else begin
            if (hist_push) begin
                hist <= {hist[max_hist-2:0], hist_taken};  // shifts only at commit
            end
            if (lookup) begin
                bank_index <= next_index;  // held until next lookup
                bank_tag   <= next_tag;
            end
        end
    end

endmodule

// ==== tage_lfsr.sv ====
`timescale 1ns/1ps

module tage_lfsr #(
    parameter logic [7:0] lfsr_seed = 8'hff
)(
    input  logic       clk,
    input  logic       reset,
    input  logic       step,
    output logic [7:0] random_num
);

    logic [7:0] state;

    // galois form, taps 8 6 5 4
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lfsr_seed;
        end else if (step) begin
            state <= {1'b0, state[7:1]} ^ (state[0] ? 8'hb8 : 8'h00);
        end
    end

    assign random_num = state;  // caller compares against 170

endmodule

// ==== tage_pkg.sv ====
package tage_pkg;

    //////////////////////////////////////////////////
    // table geometry
    //////////////////////////////////////////////////

    localparam int num_banks   = 4;
    localparam int ctr_bits    = 3;  // msb is the direction
    localparam int useful_bits = 2;

    // counter given to a freshly allocated entry
    localparam logic [ctr_bits-1:0] ctr_weak_taken     = 3'd4;
    localparam logic [ctr_bits-1:0] ctr_weak_not_taken = 3'd3;

    //////////////////////////////////////////////////
    // history lengths, geometric series
    //////////////////////////////////////////////////

    localparam int hist_len_0 = 10;
    localparam int hist_len_1 = 20;
    localparam int hist_len_2 = 40;
    localparam int hist_len_3 = 80;
    localparam int max_hist   = 80;  // width of the global history

    // per table lookup, shortest first
    localparam int hist_lens [num_banks] = '{hist_len_0, hist_len_1, hist_len_2, hist_len_3};

endpackage

// ==== tage_predictor.sv ====
`timescale 1ns/1ps

module tage_predictor
    import tage_pkg::*;
#(
    parameter int index_bits = 6,
    parameter int tag_bits   = 8
)(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   lookup_done,
    input  logic [num_banks-1:0][index_bits-1:0]   bank_index,
    input  logic [num_banks-1:0][tag_bits-1:0]     bank_tag,
    input  logic [num_banks-1:0][ctr_bits-1:0]     bank_ctr,
    input  logic [num_banks-1:0][useful_bits-1:0]  bank_useful,
    input  logic [num_banks-1:0]                   bank_hit,
    input  logic [7:0]                             random_num,
    output logic                                   pred_valid,
    output logic                                   pred_taken,
    output logic                                   pred_hit,
    output logic [1:0]                             pred_provider,
    input  logic                                   commit_start,
    input  logic                                   commit_taken,
    output logic [num_banks-1:0]                   update_en,
    output logic [num_banks-1:0][index_bits-1:0]   update_index,
    output logic [num_banks-1:0][tag_bits-1:0]     update_tag,
    output logic [num_banks-1:0][ctr_bits-1:0]     update_ctr,
    output logic [num_banks-1:0]                   set_entry,
    output logic [num_banks-1:0]                   inc_useful,
    output logic [num_banks-1:0]                   dec_useful
);

    //////////////////////////////////////////////////
    // provider, alternate and allocation choice
    //////////////////////////////////////////////////

    logic                 any_hit;
    logic [1:0]           provider;
    logic                 has_alt;
    logic [num_banks-1:0] cand;  // free tables above the provider
    logic [1:0]           primary;
    logic [1:0]           secondary;
    logic                 has_second;

    assign any_hit = |bank_hit;

    always_comb begin
        provider = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (bank_hit[b]) begin
                provider = 2'(b);  // highest hit wins
            end
        end
        has_alt = 1'b0;
        for (int b = 0; b < num_banks; b++) begin
            if (bank_hit[b] && b < provider) begin
                has_alt = 1'b1;
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            cand[b] = (bank_useful[b] == '0) && (!any_hit || b > provider);
        end
    end

    always_comb begin : pick_candidates
        logic found;
        found      = 1'b0;
        has_second = 1'b0;
        primary    = '0;
        secondary  = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (cand[b] && !found) begin
                primary = 2'(b);  // lowest free table
                found   = 1'b1;
            end else if (cand[b] && !has_second) begin
                secondary  = 2'(b);
                has_second = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // prediction record
    //////////////////////////////////////////////////

    logic                                 rec_has_alt;
    logic [ctr_bits-1:0]                  rec_ctr;
    logic [num_banks-1:0][index_bits-1:0] rec_index;
    logic [num_banks-1:0][tag_bits-1:0]   rec_tag;
    logic [1:0]                           rec_target;
    logic                                 rec_has_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid     <= 1'b0;
            pred_taken     <= 1'b0;
            pred_hit       <= 1'b0;
            pred_provider  <= '0;
            rec_has_alt    <= 1'b0;
            rec_has_target <= 1'b0;
        end else if (lookup_done) begin
            pred_valid     <= 1'b1;
            pred_taken     <= any_hit && bank_ctr[provider][ctr_bits-1];  // miss is not-taken
            pred_hit       <= any_hit;
            pred_provider  <= provider;
            rec_has_alt    <= has_alt;
            rec_has_target <= |cand;
        end else if (commit_start) begin
            pred_valid <= 1'b0;  // record consumed
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_done) begin
            rec_ctr    <= bank_ctr[provider];
            rec_index  <= bank_index;
            rec_tag    <= bank_tag;
            // roughly 2/3 toward the shorter candidate
            rec_target <= (random_num < 8'd170 || !has_second) ? primary : secondary;
        end
    end

    //////////////////////////////////////////////////
    // commit update rules
    //////////////////////////////////////////////////

    logic mispredict;

    assign mispredict   = commit_taken != pred_taken;
    assign update_index = rec_index;  // one branch in flight, so one index per table
    assign update_tag   = rec_tag;

    always_comb begin
        update_en  = '0;
        update_ctr = '0;
        set_entry  = '0;
        inc_useful = '0;
        dec_useful = '0;
        if (commit_start && pred_valid) begin
            if (pred_hit) begin
                update_en[pred_provider] = 1'b1;
                if (commit_taken) begin
                    update_ctr[pred_provider] = (rec_ctr == '1) ? rec_ctr : rec_ctr + 1'b1;
                end else begin
                    update_ctr[pred_provider] = (rec_ctr == '0) ? rec_ctr : rec_ctr - 1'b1;
                end
                if (rec_has_alt) begin  // useful only moves when the alternate also hit
                    inc_useful[pred_provider] = !mispredict;
                    dec_useful[pred_provider] = mispredict;
                end
            end
            if (mispredict && (!pred_hit || pred_provider != 2'(num_banks - 1))) begin
                if (rec_has_target) begin
                    update_en[rec_target]  = 1'b1;
                    set_entry[rec_target]  = 1'b1;
                    update_ctr[rec_target] = commit_taken ? ctr_weak_taken : ctr_weak_not_taken;
                end else begin
                    // nothing free, age every longer table
                    for (int b = 0; b < num_banks; b++) begin
                        if (!pred_hit || b > pred_provider) begin
                            dec_useful[b] = 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== tage_tb.sv ====
`timescale 1ns/1ps

module tage_tb
    import tage_pkg::*;
;

    localparam int idx_w = 6;
    localparam int tag_w = 8;
    localparam int max_wait = 100;  // cycles per handshake wait

    logic        clk;
    logic        reset;
    logic        pred_req;
    logic [31:0] pred_pc;
    logic        pred_ack;
    logic        pred_taken;
    logic        pred_hit;
    logic [1:0]  pred_provider;
    logic        commit_req;
    logic        commit_taken;
    logic        commit_ack;
    logic        refresh_hi;
    logic        refresh_lo;

    tage_top #(.index_bits(idx_w), .tag_bits(tag_w), .lfsr_seed(8'hff)) UUT (
        .clk(clk), .reset(reset),
        .pred_req(pred_req), .pred_pc(pred_pc), .pred_ack(pred_ack),
        .pred_taken(pred_taken), .pred_hit(pred_hit), .pred_provider(pred_provider),
        .commit_req(commit_req), .commit_taken(commit_taken), .commit_ack(commit_ack),
        .refresh_hi(refresh_hi), .refresh_lo(refresh_lo)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    int          errors;
    int          checks;
    int          n_preds;
    int          n_compared;
    logic [31:0] rng_state;
    logic        exp_taken;
    logic        exp_hit;
    logic [1:0]  exp_prov;
    logic        got_taken;
    logic        got_hit;
    logic [1:0]  got_prov;
    logic        prev_ack;

    //////////////////////////////////////////////////
    // reference model state
    //////////////////////////////////////////////////

    logic [max_hist-1:0] m_hist;  // bit 0 newest
    logic                m_valid  [num_banks][1 << idx_w];
    logic [tag_w-1:0]    m_tag    [num_banks][1 << idx_w];
    int                  m_ctr    [num_banks][1 << idx_w];
    int                  m_useful [num_banks][1 << idx_w];
    logic [7:0]          m_lfsr;

    // record of the branch in flight
    logic [idx_w-1:0] r_idx [num_banks];
    logic [tag_w-1:0] r_tag [num_banks];
    logic             r_hit;
    logic             r_alt;
    logic             r_taken;
    int               r_prov;
    int               r_target;
    logic             r_has_target;

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // 32-bit galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rng_state[0]};
            rng_state = rng_state[0] ? ((rng_state >> 1) ^ 32'h80200003) : (rng_state >> 1);
        end
        return v;
    endfunction

    // xor the first len history bits together in chunks of width
    function automatic logic [31:0] fold_hist(input logic [max_hist-1:0] h, input int len,
                                              input int width);
        logic [127:0] m;
        logic [31:0]  f;
        m = {48'b0, h} & ((128'd1 << len) - 1);
        f = '0;
        for (int k = 0; k * width < max_hist; k++) begin
            f = f ^ 32'((m >> (k * width)) & ((128'd1 << width) - 1));
        end
        return f;
    endfunction

    // expected {taken, hit, provider} for a lookup at pc
    function automatic logic [3:0] predict_ref(input logic [31:0] pc);
        logic [31:0] fi;
        logic [31:0] ft;
        int          prim;
        int          sec;
        logic        has_p;
        logic        has_s;
        r_hit = 1'b0;
        r_alt = 1'b0;
        r_prov = 0;
        has_p = 1'b0;
        has_s = 1'b0;
        prim = 0;
        sec = 0;
        for (int b = 0; b < num_banks; b++) begin
            fi = fold_hist(m_hist, hist_lens[b], idx_w);
            ft = fold_hist(m_hist, hist_lens[b], tag_w);
            r_idx[b] = pc[2 +: idx_w] ^ fi[idx_w-1:0];
            r_tag[b] = pc[2+idx_w +: tag_w] ^ {ft[tag_w-2:0], ft[tag_w-1]};
            if (m_valid[b][r_idx[b]] && m_tag[b][r_idx[b]] == r_tag[b]) begin
                if (r_hit) r_alt = 1'b1;  // a lower table hit too
                r_hit = 1'b1;
                r_prov = b;
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            if (m_useful[b][r_idx[b]] == 0 && (!r_hit || b > r_prov)) begin
                if (!has_p) begin
                    prim = b;
                    has_p = 1'b1;
                end else if (!has_s) begin
                    sec = b;
                    has_s = 1'b1;
                end
            end
        end
        r_has_target = has_p;
        r_target = (m_lfsr < 8'd170 || !has_s) ? prim : sec;
        m_lfsr = m_lfsr[0] ? ((m_lfsr >> 1) ^ 8'hb8) : (m_lfsr >> 1);
        r_taken = r_hit && m_ctr[r_prov][r_idx[r_prov]] >= 4;
        return {r_taken, r_hit, 2'(r_prov)};
    endfunction

    task automatic commit_ref(input logic taken);
        logic mis;
        int   c;
        int   p;
        mis = taken != r_taken;
        p = r_prov;
        if (r_hit) begin
            c = m_ctr[p][r_idx[p]];
            m_ctr[p][r_idx[p]] = taken ? (c < 7 ? c + 1 : 7) : (c > 0 ? c - 1 : 0);
            if (r_alt && !mis && m_useful[p][r_idx[p]] < 3) m_useful[p][r_idx[p]]++;
            if (r_alt && mis && m_useful[p][r_idx[p]] > 0) m_useful[p][r_idx[p]]--;
        end
        if (mis && (!r_hit || p != num_banks - 1)) begin
            if (r_has_target) begin
                m_valid[r_target][r_idx[r_target]]  = 1'b1;
                m_tag[r_target][r_idx[r_target]]    = r_tag[r_target];
                m_ctr[r_target][r_idx[r_target]]    = taken ? 4 : 3;
                m_useful[r_target][r_idx[r_target]] = 0;
            end else begin
                for (int b = 0; b < num_banks; b++) begin
                    if ((!r_hit || b > p) && m_useful[b][r_idx[b]] > 0) m_useful[b][r_idx[b]]--;
                end
            end
        end
        m_hist = {m_hist[max_hist-2:0], taken};
    endtask

    //////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////

    always @(negedge clk) begin : compare_pred
        if (pred_ack && !prev_ack) begin  // fresh prediction
            check_equal(pred_taken, exp_taken, "pred_taken");
            check_equal(pred_hit, exp_hit, "pred_hit");
            check_equal(pred_provider, exp_prov, "pred_provider");
            n_compared++;
        end
        prev_ack = pred_ack;
    end

    task automatic wait_ack(input logic on_commit, input logic level, input string what);
        int n;
        n = 0;
        while ((on_commit ? commit_ack : pred_ack) !== level) begin
            @(negedge clk);
            n++;
            if (n > max_wait) abort_run({"timed out waiting for ", what});
        end
    endtask

    task automatic run_branch(input logic [31:0] pc, input logic taken, input int delay);
        logic [3:0] e;
        e = predict_ref(pc);
        {exp_taken, exp_hit, exp_prov} = e;
        pred_pc  = pc;
        pred_req = 1'b1;
        n_preds++;
        wait_ack(1'b0, 1'b1, "pred_ack to rise");
        got_taken = pred_taken;
        got_hit   = pred_hit;
        got_prov  = pred_provider;
        repeat (delay) @(negedge clk);
        pred_req = 1'b0;
        wait_ack(1'b0, 1'b0, "pred_ack to fall");
        commit_ref(taken);
        commit_taken = taken;
        commit_req   = 1'b1;
        wait_ack(1'b1, 1'b1, "commit_ack to rise");
        repeat (delay) @(negedge clk);
        commit_req = 1'b0;
        wait_ack(1'b1, 1'b0, "commit_ack to fall");
    endtask

    task automatic pulse_refresh(input logic hi);
        if (hi) refresh_hi = 1'b1;
        else refresh_lo = 1'b1;
        @(negedge clk);
        refresh_hi = 1'b0;
        refresh_lo = 1'b0;
        for (int b = 0; b < num_banks; b++) begin
            for (int i = 0; i < (1 << idx_w); i++) begin
                m_useful[b][i] = hi ? (m_useful[b][i] & 1) : (m_useful[b][i] & 2);
            end
        end
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic random_branches(input int count);
        logic [31:0] pc;
        logic [31:0] r;
        logic        taken;
        int          delay;
        for (int k = 0; k < count; k++) begin
            pc    = 32'h0001_2000 + rand_bits(4) * 32'h144;  // 16 branch sites
            r     = rand_bits(1);
            taken = r[0];
            delay = int'(rand_bits(2));
            run_branch(pc, taken, delay);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        int   e0;
        logic seen_long;
        errors = 0;
        checks = 0;
        n_preds = 0;
        n_compared = 0;
        prev_ack = 1'b0;
        rng_state = 32'h8d83415d;
        reset = 1'b1;
        pred_req = 1'b0;
        pred_pc = '0;
        commit_req = 1'b0;
        commit_taken = 1'b0;
        refresh_hi = 1'b0;
        refresh_lo = 1'b0;
        m_hist = '0;
        m_lfsr = 8'hff;
        for (int b = 0; b < num_banks; b++) begin
            for (int i = 0; i < (1 << idx_w); i++) begin
                m_valid[b][i] = 1'b0;
                m_tag[b][i] = '0;
                m_ctr[b][i] = 0;
                m_useful[b][i] = 0;
            end
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // idle after reset then cold lookups
        e0 = errors;
        repeat (10) begin
            @(negedge clk);
            check_equal(pred_ack, 0, "pred_ack idle");
            check_equal(commit_ack, 0, "commit_ack idle");
        end
        run_branch(32'h0000_4a10, 1'b0, 0);
        check_equal(got_hit, 0, "cold pred_hit");
        check_equal(got_taken, 0, "cold pred_taken");
        run_branch(32'h0000_7734, 1'b0, 1);
        report_test("reset defaults", e0);

        // always taken branch warms up
        e0 = errors;
        run_branch(32'h0000_1c40, 1'b1, 0);
        check_equal(got_hit, 0, "first pred_hit");
        for (int k = 0; k < 100; k++) run_branch(32'h0000_1c40, 1'b1, k % 3);
        check_equal(got_hit, 1, "warm pred_hit");
        check_equal(got_taken, 1, "warm pred_taken");
        run_branch(32'h0000_1c40, 1'b0, 0);
        for (int k = 0; k < 20; k++) run_branch(32'h0000_1c40, 1'b1, 0);
        check_equal(got_taken, 1, "pred_taken after one not-taken");
        report_test("always taken", e0);

        // outcome set by old history
        e0 = errors;
        seen_long = 1'b0;
        for (int k = 0; k < 300; k++) begin
            run_branch(32'h0000_3e08, ~m_hist[34], 0);
            if (got_hit && got_prov != 2'd0) seen_long = 1'b1;
        end
        check_equal(seen_long, 1, "longer table provides");
        report_test("long history", e0);

        // refresh around a random stream
        e0 = errors;
        random_branches(60);
        pulse_refresh(1'b1);
        random_branches(30);
        pulse_refresh(1'b0);
        random_branches(30);
        pulse_refresh(1'b1);
        pulse_refresh(1'b0);
        random_branches(30);
        report_test("useful refresh", e0);

        // long random stream
        e0 = errors;
        random_branches(400);
        report_test("random stream", e0);

        repeat (4) @(negedge clk);
        check_equal(n_compared, n_preds, "predictions compared");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tage_top.sv ====
`timescale 1ns/1ps

module tage_top
    import tage_pkg::*;
#(
    parameter int         index_bits = 6,
    parameter int         tag_bits   = 8,
    parameter logic [7:0] lfsr_seed  = 8'hff
)(
    input  logic        clk,
    input  logic        reset,
    input  logic        pred_req,
    input  logic [31:0] pred_pc,
    output logic        pred_ack,
    output logic        pred_taken,
    output logic        pred_hit,
    output logic [1:0]  pred_provider,
    input  logic        commit_req,
    input  logic        commit_taken,
    output logic        commit_ack,
    input  logic        refresh_hi,
    input  logic        refresh_lo
);

    logic [num_banks-1:0][index_bits-1:0]  bank_index;
    logic [num_banks-1:0][tag_bits-1:0]    bank_tag;
    logic [num_banks-1:0][ctr_bits-1:0]    bank_ctr;
    logic [num_banks-1:0][useful_bits-1:0] bank_useful;
    logic [num_banks-1:0]                  bank_hit;
    logic [num_banks-1:0]                  update_en;
    logic [num_banks-1:0][index_bits-1:0]  update_index;
    logic [num_banks-1:0][tag_bits-1:0]    update_tag;
    logic [num_banks-1:0][ctr_bits-1:0]    update_ctr;
    logic [num_banks-1:0]                  set_entry;
    logic [num_banks-1:0]                  inc_useful;
    logic [num_banks-1:0]                  dec_useful;
    logic [7:0]                            random_num;
    logic                                  pred_valid;

    //////////////////////////////////////////////////
    // req/ack phase machines
    //////////////////////////////////////////////////

    logic pred_req_q;
    logic lookup;
    logic bank_read;
    logic lookup_done;
    logic pred_open;
    logic commit_req_q;
    logic commit_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_req_q   <= 1'b0;
            lookup       <= 1'b0;
            bank_read    <= 1'b0;
            lookup_done  <= 1'b0;
            pred_open    <= 1'b0;
            commit_req_q <= 1'b0;
            commit_start <= 1'b0;
            commit_ack   <= 1'b0;
        end else begin
            pred_req_q  <= pred_req;
            lookup      <= pred_req && !pred_req_q;  // rising edge of req
            bank_read   <= lookup;                   // hash stage
            lookup_done <= bank_read;                // bank read stage
            if (lookup) begin
                pred_open <= 1'b1;
            end else if (!pred_req_q) begin
                pred_open <= 1'b0;
            end

            commit_req_q <= commit_req;
            commit_start <= commit_req && !commit_req_q;
            if (commit_start) begin
                commit_ack <= 1'b1;  // same edge as the table writes
            end else if (!commit_req_q) begin
                commit_ack <= 1'b0;
            end
        end
    end

    assign pred_ack = pred_open && pred_valid;  // up once the record lands

    //////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////

    tage_hash #(.index_bits(index_bits), .tag_bits(tag_bits)) hash (
        .clk(clk), .reset(reset), .lookup(lookup), .pc(pred_pc),
        .hist_push(commit_start), .hist_taken(commit_taken),
        .bank_index(bank_index), .bank_tag(bank_tag)
    );

    for (genvar g = 0; g < num_banks; g++) begin : banks
        tage_bank #(
            .index_bits(index_bits), .tag_bits(tag_bits), .hist_len(hist_lens[g])
        ) bank (
            .clk(clk), .reset(reset), .lookup_valid(bank_read),
            .index(bank_index[g]), .tag(bank_tag[g]),
            .ctr_out(bank_ctr[g]), .useful_out(bank_useful[g]), .hit_out(bank_hit[g]),
            .update_en(update_en[g]), .update_index(update_index[g]),
            .update_tag(update_tag[g]), .update_ctr(update_ctr[g]),
            .set_entry(set_entry[g]), .inc_useful(inc_useful[g]), .dec_useful(dec_useful[g]),
            .refresh_hi(refresh_hi), .refresh_lo(refresh_lo)
        );
    end

    tage_predictor #(.index_bits(index_bits), .tag_bits(tag_bits)) predictor (
        .clk(clk), .reset(reset), .lookup_done(lookup_done),
        .bank_index(bank_index), .bank_tag(bank_tag),
        .bank_ctr(bank_ctr), .bank_useful(bank_useful), .bank_hit(bank_hit),
        .random_num(random_num),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_hit(pred_hit),
        .pred_provider(pred_provider),
        .commit_start(commit_start), .commit_taken(commit_taken),
        .update_en(update_en), .update_index(update_index), .update_tag(update_tag),
        .update_ctr(update_ctr), .set_entry(set_entry),
        .inc_useful(inc_useful), .dec_useful(dec_useful)
    );

    // steps on the edge that raises pred_ack
    tage_lfsr #(.lfsr_seed(lfsr_seed)) lfsr (
        .clk(clk), .reset(reset), .step(lookup_done), .random_num(random_num)
    );

endmodule
